// ==== flist.f ====
rtl/fetch_ctrl_pkg.sv
rtl/pma_pkg.sv
rtl/prefetch_unit.sv
rtl/fetch_mpu.sv
rtl/instr_bus_if.sv
rtl/if_stage.sv
tests/if_stage_asserts.sv
tests/fetch_mem_model.sv
tests/tb_if_stage.sv

// ==== rtl/fetch_ctrl_pkg.sv ====
// fetch control definitions: PC source selects, exception vector selects and fetch constants
`default_nettype none

package fetch_ctrl_pkg;

  //////////////////////////////
  // next-PC sources
  //////////////////////////////

  // selects the target loaded on a pc_set pulse
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_MRET      = 3'd4,
    PC_DRET      = 3'd5,
    PC_FENCEI    = 3'd6
  } pc_mux_e;

  // selects the handler address when PC_EXCEPTION is taken
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1,
    EXC_PC_DBD       = 2'd2,
    EXC_PC_DBE       = 2'd3
  } exc_pc_mux_e;

  //////////////////////////////
  // fetch constants
  //////////////////////////////

  // addi x0, x0, 0
  localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

  // word step between consecutive fetches, no compressed support
  localparam logic [31:0] FETCH_INCR = 32'd4;

endpackage

`default_nettype wire

// ==== rtl/fetch_mpu.sv ====
// fetch side MPU, passes executable fetches to the bus and answers blocked ones locally with a fault
`timescale 1ns/1ps
`default_nettype none

module fetch_mpu #(
  parameter int                  PMA_NUM_REGIONS = 0,
  parameter pma_pkg::pma_region_t PMA_CFG [PMA_NUM_REGIONS-1:0] =
    '{default: pma_pkg::PMA_R_DEFAULT}
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        core_no_txn_pend_i,
  input  logic        core_trans_valid_i,
  output logic        core_trans_ready_o,
  input  logic [31:0] core_trans_addr_i,
  output logic        core_resp_valid_o,
  output logic [31:0] core_resp_rdata_o,
  output logic        core_resp_err_o,
  output logic        bus_trans_valid_o,
  input  logic        bus_trans_ready_i,
  output logic [31:0] bus_trans_addr_o,
  input  logic        bus_resp_valid_i,
  input  logic [31:0] bus_resp_rdata_i,
  input  logic        bus_resp_err_i
);

  // region table padded to the fixed lookup size
  pma_pkg::pma_region_t cfg_pad [pma_pkg::PMA_MAX_REGIONS];

  logic exec_ok;
  logic fault_accept;
  logic fault_pend_q;

  for (genvar g = 0; g < pma_pkg::PMA_MAX_REGIONS; g++)
  begin : g_cfg
    if (g < PMA_NUM_REGIONS)
    begin : g_used
      assign cfg_pad[g] = PMA_CFG[g];
    end
    else
    begin : g_pad
      assign cfg_pad[g] = pma_pkg::PMA_R_DEFAULT;
    end
  end

  assign exec_ok = pma_pkg::pma_exec_ok(core_trans_addr_i, cfg_pad, PMA_NUM_REGIONS);

  //////////////////////////////
  // request path
  //////////////////////////////

  // executable fetches go straight through, blocked ones never reach the bus
  assign bus_trans_valid_o = core_trans_valid_i && exec_ok;
  assign bus_trans_addr_o  = core_trans_addr_i;

  // a blocked fetch waits until the bus is drained so its fault stays in order
  assign core_trans_ready_o = exec_ok ? bus_trans_ready_i : core_no_txn_pend_i;
  assign fault_accept       = core_trans_valid_i && !exec_ok && core_no_txn_pend_i;

  // fault response goes out one cycle after acceptance
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      fault_pend_q <= 1'b0;
    else
      fault_pend_q <= fault_accept;
  end

  //////////////////////////////
  // response path
  //////////////////////////////

  // bus is idle while a fault is pending, so the two never collide
  assign core_resp_valid_o = bus_resp_valid_i || fault_pend_q;
  assign core_resp_rdata_o = fault_pend_q ? fetch_ctrl_pkg::INSTR_NOP : bus_resp_rdata_i;
  assign core_resp_err_o   = fault_pend_q || bus_resp_err_i;

endmodule

`default_nettype wire

// ==== rtl/if_stage.sv ====
// instruction fetch stage top, selects the next PC, runs the prefetch path and drives the IF/ID register
`timescale 1ns/1ps
`default_nettype none

module if_stage #(
  parameter int                  PMA_NUM_REGIONS = 0,
  parameter pma_pkg::pma_region_t PMA_CFG [PMA_NUM_REGIONS-1:0] =
    '{default: pma_pkg::PMA_R_DEFAULT},
  parameter int                  FETCH_DEPTH     = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_i,
  // redirect addresses
  input  logic [31:0]                 boot_addr_i,
  input  logic [23:0]                 mtvec_addr_i,
  input  logic [31:0]                 dm_halt_addr_i,
  input  logic [31:0]                 dm_exception_addr_i,
  input  logic [31:0]                 mepc_i,
  input  logic [31:0]                 dpc_i,
  input  logic [31:0]                 jump_target_id_i,
  input  logic [31:0]                 branch_target_ex_i,
  // redirect control
  input  logic                        pc_set_i,
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [4:0]                  m_exc_vec_pc_mux_i,
  // pipeline control
  input  logic                        clear_instr_valid_i,
  input  logic                        halt_if_i,
  input  logic                        id_ready_i,
  // instruction bus
  output logic                        instr_req_o,
  output logic [31:0]                 instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  logic [31:0]                 instr_rdata_i,
  input  logic                        instr_err_i,
  // IF/ID outputs
  output logic                        instr_valid_o,
  output logic [31:0]                 instr_o,
  output logic [31:0]                 pc_id_o,
  output logic                        fetch_fault_o,
  // status
  output logic [31:0]                 pc_if_o,
  output logic                        csr_mtvec_init_o,
  output logic                        if_busy_o,
  output logic                        perf_imiss_o
);

  logic [31:0] exc_pc;
  logic [31:0] branch_addr_n;
  logic        if_valid;

  // prefetch unit to MPU
  logic        prefetch_valid;
  logic [31:0] prefetch_instr;
  logic        prefetch_err;
  logic        prefetch_busy;
  logic        core_trans_valid;
  logic        core_trans_ready;
  logic [31:0] core_trans_addr;
  logic        core_resp_valid;
  logic [31:0] core_resp_rdata;
  logic        core_resp_err;
  logic        no_txn_pend;

  // MPU to bus adapter
  logic        bus_trans_valid;
  logic        bus_trans_ready;
  logic [31:0] bus_trans_addr;
  logic        bus_resp_valid;
  logic [31:0] bus_resp_rdata;
  logic        bus_resp_err;

  //////////////////////////////
  // PC selection
  //////////////////////////////

  // handler address, interrupts vectored by cause in 128 byte table slots
  always_comb
  begin
    unique case (exc_pc_mux_i)
      fetch_ctrl_pkg::EXC_PC_EXCEPTION: exc_pc = {mtvec_addr_i, 8'h00};
      fetch_ctrl_pkg::EXC_PC_IRQ:       exc_pc = {mtvec_addr_i, 1'b0, m_exc_vec_pc_mux_i, 2'b00};
      fetch_ctrl_pkg::EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[31:2], 2'b00};
      fetch_ctrl_pkg::EXC_PC_DBE:       exc_pc = {dm_exception_addr_i[31:2], 2'b00};
      default:                          exc_pc = {mtvec_addr_i, 8'h00};
    endcase
  end

  always_comb
  begin
    unique case (pc_mux_i)
      fetch_ctrl_pkg::PC_BOOT:      branch_addr_n = {boot_addr_i[31:2], 2'b00};
      fetch_ctrl_pkg::PC_JUMP:      branch_addr_n = jump_target_id_i;
      fetch_ctrl_pkg::PC_BRANCH:    branch_addr_n = branch_target_ex_i;
      fetch_ctrl_pkg::PC_EXCEPTION: branch_addr_n = exc_pc;
      fetch_ctrl_pkg::PC_MRET:      branch_addr_n = mepc_i;
      fetch_ctrl_pkg::PC_DRET:      branch_addr_n = dpc_i;
      // refetch everything after the fence
      fetch_ctrl_pkg::PC_FENCEI:    branch_addr_n = pc_id_o + fetch_ctrl_pkg::FETCH_INCR;
      default:                      branch_addr_n = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  // mtvec gets initialised on the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == fetch_ctrl_pkg::PC_BOOT);

  // ID takes an instruction unless stalled or halted
  assign if_valid = id_ready_i && !halt_if_i;

  // miss, decode wants an instruction and none is buffered
  assign perf_imiss_o = req_i && if_valid && !prefetch_valid && !pc_set_i;
  assign if_busy_o    = prefetch_busy;

  //////////////////////////////
  // fetch path
  //////////////////////////////

  prefetch_unit #(
    .FETCH_DEPTH (FETCH_DEPTH)
  ) i_prefetch_unit (
    .clk              (clk),
    .rst_n            (rst_n),
    .prefetch_en_i    (req_i),
    .branch_i         (pc_set_i),
    .branch_addr_i    (branch_addr_n),
    .prefetch_ready_i (if_valid),
    .prefetch_valid_o (prefetch_valid),
    .prefetch_instr_o (prefetch_instr),
    .prefetch_err_o   (prefetch_err),
    .prefetch_addr_o  (pc_if_o),
    .trans_valid_o    (core_trans_valid),
    .trans_ready_i    (core_trans_ready),
    .trans_addr_o     (core_trans_addr),
    .resp_valid_i     (core_resp_valid),
    .resp_rdata_i     (core_resp_rdata),
    .resp_err_i       (core_resp_err),
    .no_txn_pend_o    (no_txn_pend),
    .prefetch_busy_o  (prefetch_busy)
  );

  fetch_mpu #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG)
  ) i_fetch_mpu (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_no_txn_pend_i (no_txn_pend),
    .core_trans_valid_i (core_trans_valid),
    .core_trans_ready_o (core_trans_ready),
    .core_trans_addr_i  (core_trans_addr),
    .core_resp_valid_o  (core_resp_valid),
    .core_resp_rdata_o  (core_resp_rdata),
    .core_resp_err_o    (core_resp_err),
    .bus_trans_valid_o  (bus_trans_valid),
    .bus_trans_ready_i  (bus_trans_ready),
    .bus_trans_addr_o   (bus_trans_addr),
    .bus_resp_valid_i   (bus_resp_valid),
    .bus_resp_rdata_i   (bus_resp_rdata),
    .bus_resp_err_i     (bus_resp_err)
  );

  instr_bus_if i_instr_bus_if (
    .clk            (clk),
    .rst_n          (rst_n),
    .trans_valid_i  (bus_trans_valid),
    .trans_ready_o  (bus_trans_ready),
    .trans_addr_i   (bus_trans_addr),
    .resp_valid_o   (bus_resp_valid),
    .resp_rdata_o   (bus_resp_rdata),
    .resp_err_o     (bus_resp_err),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  //////////////////////////////
  // IF/ID register
  //////////////////////////////

  // frozen while ID stalls, a clear only drops valid when nothing loads
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      instr_valid_o <= 1'b0;
      instr_o       <= fetch_ctrl_pkg::INSTR_NOP;
      pc_id_o       <= '0;
      fetch_fault_o <= 1'b0;
    end
    else if (if_valid && prefetch_valid)
    begin
      instr_valid_o <= 1'b1;
      instr_o       <= prefetch_instr;
      pc_id_o       <= pc_if_o;
      fetch_fault_o <= prefetch_err;
    end
    else if (clear_instr_valid_i)
      instr_valid_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== rtl/instr_bus_if.sv ====
// instruction bus adapter, maps internal fetch transactions onto the req/gnt/rvalid bus
`timescale 1ns/1ps
`default_nettype none

module instr_bus_if (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        trans_valid_i,
  output logic        trans_ready_o,
  input  logic [31:0] trans_addr_i,
  output logic        resp_valid_o,
  output logic [31:0] resp_rdata_o,
  output logic        resp_err_o,
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        instr_err_i
);

  // set while an ungranted request is parked in the hold register
  logic        held_q;
  logic [31:0] hold_addr_q;

  // transparent when idle, the internal side is accepted on valid alone
  // a parked request owns the bus until its grant, whatever upstream does
  assign trans_ready_o = !held_q;
  assign instr_req_o   = held_q || trans_valid_i;
  assign instr_addr_o  = held_q ? hold_addr_q : trans_addr_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      held_q <= 1'b0;
    else if (held_q)
      held_q <= !instr_gnt_i;
    else
      held_q <= trans_valid_i && !instr_gnt_i;
  end

  // capture the address of a request that missed its grant
  always_ff @(posedge clk)
  begin
    if (!held_q && trans_valid_i && !instr_gnt_i)
      hold_addr_q <= trans_addr_i;
  end

  // responses return in order, same cycle
  assign resp_valid_o = instr_rvalid_i;
  assign resp_rdata_o = instr_rdata_i;
  assign resp_err_o   = instr_err_i;

endmodule

`default_nettype wire

// ==== rtl/pma_pkg.sv ====
// physical memory attribute definitions and the executable-region lookup used by the fetch MPU
`default_nettype none

package pma_pkg;

  // one attribute region, match on address bits outside the mask
  typedef struct packed {
    logic [31:0] base;
    logic [31:0] mask;
    logic        exec;
  } pma_region_t;

  // upper bound on configured regions, unused slots are padded
  localparam int PMA_MAX_REGIONS = 16;

  // whole address space, executable
  localparam pma_region_t PMA_R_DEFAULT = '{base: 32'h0000_0000, mask: 32'hffff_ffff, exec: 1'b1};

  // lowest numbered matching region wins
  // no match means not executable, zero regions means everything is executable
  function automatic logic pma_exec_ok(input logic [31:0] addr,
                                       input pma_region_t cfg [PMA_MAX_REGIONS],
                                       input int          num);
    logic ok;
    logic hit;
    ok  = (num == 0);
    hit = 1'b0;
    for (int i = 0; i < PMA_MAX_REGIONS; i++)
    begin
      if ((i < num) && !hit && ((addr & ~cfg[i].mask) == (cfg[i].base & ~cfg[i].mask)))
      begin
        hit = 1'b1;
        ok  = cfg[i].exec;
      end
    end
    return ok;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/prefetch_unit.sv ====
// prefetch buffer of the fetch stage, issues word fetches ahead of decode and queues the responses
`timescale 1ns/1ps
`default_nettype none

module prefetch_unit #(
  parameter int FETCH_DEPTH = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        prefetch_en_i,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  input  logic        prefetch_ready_i,
  output logic        prefetch_valid_o,
  output logic [31:0] prefetch_instr_o,
  output logic        prefetch_err_o,
  output logic [31:0] prefetch_addr_o,
  output logic        trans_valid_o,
  input  logic        trans_ready_i,
  output logic [31:0] trans_addr_o,
  input  logic        resp_valid_i,
  input  logic [31:0] resp_rdata_i,
  input  logic        resp_err_i,
  output logic        no_txn_pend_o,
  output logic        prefetch_busy_o
);

  localparam int CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;

  // next request address and PC of the head entry
  logic [31:0]      fetch_addr_q;
  logic [31:0]      pc_q;
  // transactions in flight, split into live and flushed ones
  logic [CNT_W-1:0] out_cnt_q;
  logic [CNT_W-1:0] discard_cnt_q;
  // response queue
  logic [CNT_W-1:0] fifo_cnt_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [31:0]      fifo_rdata [FETCH_DEPTH];
  logic             fifo_err   [FETCH_DEPTH];

  logic [CNT_W:0]   occupancy;
  logic             accept;
  logic             pop;
  logic             resp_keep;
  logic             resp_drop;

  // ring pointer step
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FETCH_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // issue side
  //////////////////////////////

  // every slot counts, flushed responses still occupy the bus
  assign occupancy = out_cnt_q + discard_cnt_q + fifo_cnt_q;

  // a slot is reserved before issue, so responses never need back-pressure
  // nothing issues in a redirect cycle, the old address is stale
  assign trans_valid_o = prefetch_en_i && !branch_i && (occupancy < (CNT_W + 1)'(FETCH_DEPTH));
  assign trans_addr_o  = fetch_addr_q;
  assign accept        = trans_valid_o && trans_ready_i;

  // responses for flushed requests are eaten first, they are always older
  assign resp_drop = resp_valid_i && (discard_cnt_q != '0);
  assign resp_keep = resp_valid_i && (discard_cnt_q == '0);

  assign no_txn_pend_o   = (out_cnt_q == '0) && (discard_cnt_q == '0);
  assign prefetch_busy_o = !no_txn_pend_o;

  //////////////////////////////
  // output side
  //////////////////////////////

  // head entry is hidden while redirecting so the old stream cannot reach ID
  assign prefetch_valid_o = (fifo_cnt_q != '0) && !branch_i;
  assign prefetch_instr_o = fifo_rdata[rd_ptr_q];
  assign prefetch_err_o   = fifo_err[rd_ptr_q];
  assign prefetch_addr_o  = pc_q;
  assign pop              = prefetch_valid_o && prefetch_ready_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fetch_addr_q  <= '0;
      pc_q          <= '0;
      out_cnt_q     <= '0;
      discard_cnt_q <= '0;
      fifo_cnt_q    <= '0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
    end
    else if (branch_i)
    begin
      // flush, live requests become discards, minus whatever returns now
      fetch_addr_q  <= branch_addr_i;
      pc_q          <= branch_addr_i;
      out_cnt_q     <= '0;
      discard_cnt_q <= discard_cnt_q + out_cnt_q - CNT_W'(resp_valid_i);
      fifo_cnt_q    <= '0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
    end
    else
    begin
      if (accept)
        fetch_addr_q <= fetch_addr_q + fetch_ctrl_pkg::FETCH_INCR;
      if (pop)
        pc_q <= pc_q + fetch_ctrl_pkg::FETCH_INCR;
      out_cnt_q <= out_cnt_q + CNT_W'(accept) - CNT_W'(resp_keep);
      if (resp_drop)
        discard_cnt_q <= discard_cnt_q - CNT_W'(1);
      fifo_cnt_q <= fifo_cnt_q + CNT_W'(resp_keep) - CNT_W'(pop);
      if (resp_keep)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
    end
  end

  // queue storage
  always_ff @(posedge clk)
  begin
    if (resp_keep)
    begin
      fifo_rdata[wr_ptr_q] <= resp_rdata_i;
      fifo_err[wr_ptr_q]   <= resp_err_i;
    end
  end

endmodule

`default_nettype wire

// ==== tests/fetch_mem_model.sv ====
// instruction memory model for the fetch stage testbench, random grant and 1 to 4 cycle in-order responses
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_model #(
  parameter logic [31:0] SEED = 32'hd38b1f4d
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  output logic        instr_gnt_o,
  output logic        instr_rvalid_o,
  output logic [31:0] instr_rdata_o,
  output logic        instr_err_o
);

  localparam logic [31:0] DATA_KEY = 32'h5a5a_c3c3;

  logic [31:0] rng_state;
  int          cycle_cnt;
  // granted requests waiting for their response, oldest first
  logic [31:0] addr_q [$];
  int          due_q  [$];
  // mid-cycle samples
  logic        granted;
  logic [31:0] granted_addr;
  logic        in_reset;

  // LCG, upper bits only since the low ones repeat quickly
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {8'h00, rng_state[31:8]};
  endfunction

  // bus error window
  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= 32'h0000_6000) && (addr <= 32'h0000_60ff);
  endfunction

  initial
  begin
    rng_state      = SEED;
    cycle_cnt      = 0;
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    instr_err_o    = 1'b0;
    forever
    begin
      // all bus inputs are settled by mid cycle
      @(negedge clk);
      granted      = instr_req_i && instr_gnt_o;
      granted_addr = instr_addr_i;
      in_reset     = !rst_n;
      @(posedge clk);
      #1;
      cycle_cnt++;
      if (in_reset)
      begin
        addr_q.delete();
        due_q.delete();
        instr_gnt_o    = 1'b0;
        instr_rvalid_o = 1'b0;
      end
      else
      begin
        // the response of the past cycle was taken
        if (instr_rvalid_o)
        begin
          void'(addr_q.pop_front());
          void'(due_q.pop_front());
        end
        // earliest answer in the cycle right after the grant, latest 4 cycles after
        if (granted)
        begin
          addr_q.push_back(granted_addr);
          due_q.push_back(cycle_cnt + int'(next_rand() % 4));
        end
        // grant about three cycles in four
        instr_gnt_o    = (next_rand() % 4) != 0;
        instr_rvalid_o = (addr_q.size() > 0) && (due_q[0] <= cycle_cnt);
        if (instr_rvalid_o)
        begin
          instr_rdata_o = addr_q[0] ^ DATA_KEY;
          instr_err_o   = in_err_window(addr_q[0]);
        end
        else
        begin
          instr_rdata_o = '0;
          instr_err_o   = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/if_stage_asserts.sv ====
// concurrent assertions bound into the fetch stage top for bus request stability, quiet outputs in reset and the IF/ID hold on stall
`timescale 1ns/1ps
`default_nettype none

module if_stage_asserts (
  input logic        clk,
  input logic        rst_n,
  input logic        id_ready_i,
  input logic        clear_instr_valid_i,
  input logic        instr_req_o,
  input logic [31:0] instr_addr_o,
  input logic        instr_gnt_i,
  input logic        instr_valid_o,
  input logic [31:0] instr_o,
  input logic [31:0] pc_id_o,
  input logic        fetch_fault_o,
  input logic        csr_mtvec_init_o,
  input logic        perf_imiss_o
);

  // number of failed assertions
  int fail_cnt = 0;

  // an ungranted request keeps request and address
  req_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else
    begin
      fail_cnt++;
      $error("instr_req_o or instr_addr_o changed before the grant");
    end

  reset_quiet_a : assert property (@(posedge clk)
    !rst_n |-> !instr_req_o && !instr_valid_o && !csr_mtvec_init_o && !perf_imiss_o)
    else
    begin
      fail_cnt++;
      $error("outputs active while in reset");
    end

  // IF/ID register frozen while ID stalls
  stall_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable(instr_o) && $stable(pc_id_o) && $stable(fetch_fault_o))
    else
    begin
      fail_cnt++;
      $error("IF/ID contents changed while id_ready_i was low");
    end

  stall_valid_a : assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i && !clear_instr_valid_i |=> $stable(instr_valid_o))
    else
    begin
      fail_cnt++;
      $error("instr_valid_o changed while id_ready_i was low");
    end

endmodule

bind if_stage if_stage_asserts i_if_stage_asserts (.*);

`default_nettype wire

// ==== tests/tb_if_stage.sv ====
// simulation top that drives the fetch stage with random redirects and stalls and checks it against an IF/ID model
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

  localparam int          STEPS      = 2000;
  localparam int          TIMEOUT_NS = STEPS * 40 + 1000;
  localparam logic [31:0] SEED       = 32'hd38b1f4d;
  localparam logic [31:0] DATA_KEY   = 32'h5a5a_c3c3;

  // index 0 covers the executable low 32 KiB and index 1 the blocked 4 KiB above it
  localparam pma_pkg::pma_region_t PMA_CFG [1:0] = '{
    '{base: 32'h0000_8000, mask: 32'h0000_0fff, exec: 1'b0},
    '{base: 32'h0000_0000, mask: 32'h0000_7fff, exec: 1'b1}
  };

  logic clk;
  logic rst_n;
  logic req;
  logic [31:0] boot_addr;
  logic [23:0] mtvec_addr;
  logic [31:0] dm_halt_addr;
  logic [31:0] dm_exception_addr;
  logic [31:0] mepc;
  logic [31:0] dpc;
  logic [31:0] jump_target;
  logic [31:0] branch_target;
  logic pc_set;
  fetch_ctrl_pkg::pc_mux_e pc_mux;
  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux;
  logic [4:0] exc_cause;
  logic clear_instr_valid;
  logic halt_if;
  logic id_ready;
  logic instr_req;
  logic [31:0] instr_addr;
  logic instr_gnt;
  logic instr_rvalid;
  logic [31:0] instr_rdata;
  logic instr_err;
  logic instr_valid;
  logic [31:0] instr;
  logic [31:0] pc_id;
  logic fetch_fault;
  logic [31:0] pc_if;
  logic csr_mtvec_init;
  logic if_busy;
  logic perf_imiss;

  // reference model of the IF/ID register and the next PC to load
  logic        m_valid;
  logic [31:0] m_instr;
  logic [31:0] m_pc;
  logic        m_fault;
  logic [31:0] exp_pc;

  // granted bus requests still waiting for their response
  int bus_pend;

  logic [31:0] rng_state;
  int err_cnt;
  int check_cnt;
  int load_cnt;
  int redirect_cnt;
  int fault_cnt;

  if_stage #(
    .PMA_NUM_REGIONS (2),
    .PMA_CFG         (PMA_CFG),
    .FETCH_DEPTH     (2)
  ) i_if_stage (
    .clk (clk), .rst_n (rst_n), .req_i (req),
    .boot_addr_i (boot_addr), .mtvec_addr_i (mtvec_addr),
    .dm_halt_addr_i (dm_halt_addr), .dm_exception_addr_i (dm_exception_addr),
    .mepc_i (mepc), .dpc_i (dpc),
    .jump_target_id_i (jump_target), .branch_target_ex_i (branch_target),
    .pc_set_i (pc_set), .pc_mux_i (pc_mux), .exc_pc_mux_i (exc_pc_mux),
    .m_exc_vec_pc_mux_i (exc_cause),
    .clear_instr_valid_i (clear_instr_valid), .halt_if_i (halt_if), .id_ready_i (id_ready),
    .instr_req_o (instr_req), .instr_addr_o (instr_addr), .instr_gnt_i (instr_gnt),
    .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata), .instr_err_i (instr_err),
    .instr_valid_o (instr_valid), .instr_o (instr), .pc_id_o (pc_id),
    .fetch_fault_o (fetch_fault), .pc_if_o (pc_if), .csr_mtvec_init_o (csr_mtvec_init),
    .if_busy_o (if_busy), .perf_imiss_o (perf_imiss)
  );

  fetch_mem_model #(
    .SEED (SEED)
  ) i_fetch_mem_model (
    .clk (clk), .rst_n (rst_n),
    .instr_req_i (instr_req), .instr_addr_i (instr_addr), .instr_gnt_o (instr_gnt),
    .instr_rvalid_o (instr_rvalid), .instr_rdata_o (instr_rdata), .instr_err_o (instr_err)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {8'h00, rng_state[31:8]};
  endfunction

  // mostly plain code with some targets near the blocked boundary or inside it or in the error window
  function automatic logic [31:0] random_target();
    logic [31:0] r;
    logic [31:0] t;
    r = next_rand();
    case (r[2:0])
      3'd5:    t = 32'h0000_7ff0 | {28'h0, r[4:3], 2'b00};
      3'd6:    t = 32'h0000_8000 | ((r >> 3) & 32'h0000_0ffc);
      3'd7:    t = 32'h0000_6000 | ((r >> 3) & 32'h0000_00fc);
      default: t = (r >> 3) & 32'h0000_7ffc;
    endcase
    return t;
  endfunction

  // anything at or above 0x8000 is outside the executable region
  function automatic logic blocked(input logic [31:0] p);
    return p >= 32'h0000_8000;
  endfunction

  function automatic logic [31:0] redirect_target();
    logic [31:0] vec;
    logic [31:0] t;
    case (exc_pc_mux)
      fetch_ctrl_pkg::EXC_PC_IRQ: vec = {mtvec_addr, 1'b0, exc_cause, 2'b00};
      fetch_ctrl_pkg::EXC_PC_DBD: vec = dm_halt_addr & ~32'h3;
      fetch_ctrl_pkg::EXC_PC_DBE: vec = dm_exception_addr & ~32'h3;
      default:                    vec = {mtvec_addr, 8'h00};
    endcase
    case (pc_mux)
      fetch_ctrl_pkg::PC_BOOT:   t = boot_addr & ~32'h3;
      fetch_ctrl_pkg::PC_JUMP:   t = jump_target;
      fetch_ctrl_pkg::PC_BRANCH: t = branch_target;
      fetch_ctrl_pkg::PC_MRET:   t = mepc;
      fetch_ctrl_pkg::PC_DRET:   t = dpc;
      fetch_ctrl_pkg::PC_FENCEI: t = m_pc + 32'd4;
      default:                   t = vec;
    endcase
    return t;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    err_cnt++;
    $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, exp, got);
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = next_rand();
    id_ready          = r[2:0] != 3'd0;
    halt_if           = r[6:3] == 4'd0;
    clear_instr_valid = r[10:7] == 4'd0;
    pc_set            = r[14:11] == 4'd0;
    exc_pc_mux        = fetch_ctrl_pkg::exc_pc_mux_e'(r[16:15]);
    exc_cause         = r[21:17];
    pc_mux            = fetch_ctrl_pkg::pc_mux_e'(3'(next_rand() % 7));
    jump_target       = random_target();
    branch_target     = random_target();
    mepc              = random_target();
    dpc               = random_target();
    // low bits left set to see them cleared
    boot_addr         = random_target() | (next_rand() % 4);
    dm_halt_addr      = random_target() | (next_rand() % 4);
    dm_exception_addr = random_target() | (next_rand() % 4);
    mtvec_addr        = 24'(next_rand() % 32'h80);
  endtask

  // compare at mid cycle and then step the model over the coming edge
  task automatic check_cycle();
    logic load;
    logic exp_init;
    check_cnt++;
    if (instr_valid !== m_valid)
      report_mismatch("instr_valid_o", m_valid, instr_valid);
    if (instr !== m_instr)
      report_mismatch("instr_o", m_instr, instr);
    if (pc_id !== m_pc)
      report_mismatch("pc_id_o", m_pc, pc_id);
    if (fetch_fault !== m_fault)
      report_mismatch("fetch_fault_o", m_fault, fetch_fault);
    // head of the buffer always carries the next PC that ID will load
    if (pc_if !== exp_pc)
      report_mismatch("pc_if_o", exp_pc, pc_if);
    exp_init = pc_set && (pc_mux == fetch_ctrl_pkg::PC_BOOT);
    if (csr_mtvec_init !== exp_init)
      report_mismatch("csr_mtvec_init_o", exp_init, csr_mtvec_init);
    if (instr_req && (instr_addr >= 32'h0000_8000) && (instr_addr <= 32'h0000_8fff))
      report_failure($sformatf("bus request to blocked address %0h", instr_addr));
    if (perf_imiss && !(id_ready && !halt_if))
      report_failure("perf_imiss_o high while ID does not want an instruction");
    // a granted request counts as outstanding until its response
    if ((bus_pend > 0) && !if_busy)
      report_failure($sformatf("if_busy_o low with %0d bus responses outstanding", bus_pend));
    bus_pend = bus_pend + int'(instr_req && instr_gnt) - int'(instr_rvalid);
    // with ID ready and no redirect a miss means an empty buffer
    load = id_ready && !halt_if && !pc_set && !perf_imiss;
    if (pc_set)
    begin
      exp_pc = redirect_target();
      redirect_cnt++;
      if (clear_instr_valid)
        m_valid = 1'b0;
    end
    else if (load)
    begin
      m_valid = 1'b1;
      m_pc    = exp_pc;
      m_instr = blocked(exp_pc) ? fetch_ctrl_pkg::INSTR_NOP : (exp_pc ^ DATA_KEY);
      m_fault = blocked(exp_pc) ||
                ((exp_pc >= 32'h0000_6000) && (exp_pc <= 32'h0000_60ff));
      exp_pc  = exp_pc + 32'd4;
      load_cnt++;
      if (m_fault)
        fault_cnt++;
    end
    else if (clear_instr_valid)
      m_valid = 1'b0;
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    clk = 1'b0;
    rst_n = 1'b0;
    req = 1'b0;
    boot_addr = '0;
    mtvec_addr = '0;
    dm_halt_addr = '0;
    dm_exception_addr = '0;
    mepc = '0;
    dpc = '0;
    jump_target = '0;
    branch_target = '0;
    pc_set = 1'b0;
    pc_mux = fetch_ctrl_pkg::PC_BOOT;
    exc_pc_mux = fetch_ctrl_pkg::EXC_PC_EXCEPTION;
    exc_cause = '0;
    clear_instr_valid = 1'b0;
    halt_if = 1'b0;
    id_ready = 1'b0;
    rng_state = SEED;
    err_cnt = 0;
    check_cnt = 0;
    load_cnt = 0;
    redirect_cnt = 0;
    fault_cnt = 0;
    bus_pend = 0;
    // reset state of IF/ID and the fetch counter
    m_valid = 1'b0;
    m_instr = fetch_ctrl_pkg::INSTR_NOP;
    m_pc = '0;
    m_fault = 1'b0;
    exp_pc = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    req = 1'b1;
    for (int step = 0; step < STEPS; step++)
    begin
      @(negedge clk);
      check_cycle();
      @(posedge clk);
      #1;
      drive_inputs();
    end
    // stop fetching and stall ID while the outstanding responses drain
    req = 1'b0;
    pc_set = 1'b0;
    id_ready = 1'b0;
    clear_instr_valid = 1'b0;
    do
    begin
      @(negedge clk);
      check_cycle();
      @(posedge clk);
      #1;
    end
    while (if_busy);
    if (bus_pend != 0)
      report_failure($sformatf("%0d bus responses outstanding after if_busy_o fell", bus_pend));
    if (load_cnt < STEPS / 20)
      report_failure($sformatf("only %0d instructions reached ID", load_cnt));
    if (fault_cnt == 0)
      report_failure("no faulting fetch reached ID");
    $display("checks %0d, errors %0d, assertion failures %0d, loads %0d, redirects %0d, faults %0d",
             check_cnt, err_cnt, i_if_stage.i_if_stage_asserts.fail_cnt, load_cnt,
             redirect_cnt, fault_cnt);
    if ((err_cnt == 0) && (i_if_stage.i_if_stage_asserts.fail_cnt == 0))
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("ERROR: watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
